/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gaussian_blur
FLAGS     ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' verilog.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) verilog.f
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f verilog.f

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/blur_pkg.sv */
package blur_pkg;

  // Image geometry
  localparam int ROWS      = 480;
  localparam int STRIPS    = 40;
  localparam int STRIP_PIX = 16;
  localparam int HALO      = 3;

  localparam int PIX_W      = 8;
  localparam int ROW_ADDR_W = 9;
  localparam int COL_W      = 6;

  localparam int PRELOAD_CYCLES = 3;
  // Address register, SRAM latency, merge register
  localparam int READ_TO_WRITE  = 3;

  localparam int BUF_PIX = STRIP_PIX + 2 * HALO;
  localparam int STRIP_W = STRIP_PIX * PIX_W;
  localparam int ROW_W   = STRIPS * STRIP_W;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    ROW_PASS
  } seq_state_e;

  // Strip 0 sits in the most significant bits
  typedef union packed {
    logic [ROW_W-1:0]                                  flat;
    logic [0:STRIPS-1][STRIP_PIX-1:0][PIX_W-1:0]       strips;
  } row_word_u;

endpackage

/* hdl/gauss3_kernel.sv */
`timescale 1ns/1ps

module gauss3_kernel import blur_pkg::*; (
  input  logic [BUF_PIX-1:0][PIX_W-1:0]   buf_row_0,
  input  logic [BUF_PIX-1:0][PIX_W-1:0]   buf_row_1,
  input  logic [BUF_PIX-1:0][PIX_W-1:0]   buf_row_2,
  output logic [STRIP_PIX-1:0][PIX_W-1:0] strip_out
);

  // Horizontal 1-2-1 tap on one buffer row
  function automatic logic [PIX_W+1:0] tap121(
    input logic [PIX_W-1:0] left,
    input logic [PIX_W-1:0] mid,
    input logic [PIX_W-1:0] right
  );
    return {2'b00, left} + {1'b0, mid, 1'b0} + {2'b00, right};
  endfunction

  always_comb begin
    logic [PIX_W+1:0] t0, t1, t2;
    logic [PIX_W+3:0] acc;
    for (int i = 0; i < STRIP_PIX; i++) begin
      // Centre pixel sits HALO past the output index
      t0 = tap121(buf_row_0[i+HALO-1], buf_row_0[i+HALO], buf_row_0[i+HALO+1]);
      t1 = tap121(buf_row_1[i+HALO-1], buf_row_1[i+HALO], buf_row_1[i+HALO+1]);
      t2 = tap121(buf_row_2[i+HALO-1], buf_row_2[i+HALO], buf_row_2[i+HALO+1]);
      // Vertical 1-2-1 with total weight 16
      acc = {2'b00, t0} + {1'b0, t1, 1'b0} + {2'b00, t2};
      strip_out[i] = acc[PIX_W+3:4];
    end
  end

endmodule

/* hdl/gaussian_blur.sv */
`timescale 1ns/1ps

module gaussian_blur import blur_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  output logic                     done,
  output logic [ROW_ADDR_W-1:0]    img_addr,
  output logic                     buffer_we,
  output logic                     fill_zero,
  output logic [COL_W-1:0]         current_col,
  input  logic [BUF_PIX*PIX_W-1:0] buf_row_0,
  input  logic [BUF_PIX*PIX_W-1:0] buf_row_1,
  input  logic [BUF_PIX*PIX_W-1:0] buf_row_2,
  output logic [ROW_ADDR_W-1:0]    blur_addr_r,
  input  logic [ROW_W-1:0]         blur_dout,
  output logic [ROW_ADDR_W-1:0]    blur_addr_w,
  output logic [ROW_W-1:0]         blur_din,
  output logic                     blur_we
);

  row_pass_if rp ();

  logic [STRIP_PIX-1:0][PIX_W-1:0] blur_strip;
  row_word_u dout_word;
  row_word_u din_word;

  // Blur SRAM words travel flat on the pins
  assign dout_word.flat = blur_dout;
  assign blur_din       = din_word.flat;
  assign current_col    = rp.current_col;

  strip_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .rp        (rp.sequencer),
    .done      (done),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .img_addr  (img_addr)
  );

  gauss3_kernel u_kernel (
    .buf_row_0 (buf_row_0),
    .buf_row_1 (buf_row_1),
    .buf_row_2 (buf_row_2),
    .strip_out (blur_strip)
  );

  row_writeback u_wb (
    .clk         (clk),
    .rst_n       (rst_n),
    .rp          (rp.writeback),
    .blur_strip  (blur_strip),
    .blur_dout   (dout_word),
    .blur_addr_r (blur_addr_r),
    .blur_addr_w (blur_addr_w),
    .blur_din    (din_word),
    .blur_we     (blur_we)
  );

endmodule

/* hdl/row_pass_if.sv */
`timescale 1ns/1ps

interface row_pass_if import blur_pkg::*; ();

  logic             row_phase;
  logic             strip_clear;
  logic [COL_W-1:0] current_col;
  logic             row_done;

  modport sequencer (
    output row_phase, strip_clear, current_col,
    input  row_done
  );

  modport writeback (
    input  row_phase, strip_clear, current_col,
    output row_done
  );

endinterface

/* hdl/row_writeback.sv */
`timescale 1ns/1ps

module row_writeback import blur_pkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  row_pass_if.writeback                   rp,
  input  logic [STRIP_PIX-1:0][PIX_W-1:0] blur_strip,
  input  row_word_u                       blur_dout,
  output logic [ROW_ADDR_W-1:0]           blur_addr_r,
  output logic [ROW_ADDR_W-1:0]           blur_addr_w,
  output row_word_u                       blur_din,
  output logic                            blur_we
);

  logic [ROW_ADDR_W-1:0]    addr_relay [READ_TO_WRITE];
  logic [READ_TO_WRITE-1:0] vld_relay;
  logic                     rd_valid;
  row_word_u                merged;

  assign rd_valid = rp.row_phase && (blur_addr_r < ROW_ADDR_W'(ROWS));

  // One row read per ROW_PASS cycle until it parks at ROWS
  always_ff @(posedge clk) begin
    if (!rst_n || rp.strip_clear)
      blur_addr_r <= '0;
    else if (rd_valid)
      blur_addr_r <= blur_addr_r + 1'b1;
  end

  // Read address follows the data to the write port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_relay <= '0;
      for (int i = 0; i < READ_TO_WRITE; i++)
        addr_relay[i] <= '0;
    end else begin
      vld_relay     <= {vld_relay[READ_TO_WRITE-2:0], rd_valid};
      addr_relay[0] <= blur_addr_r;
      for (int i = 1; i < READ_TO_WRITE; i++)
        addr_relay[i] <= addr_relay[i-1];
    end
  end

  assign blur_addr_w = addr_relay[READ_TO_WRITE-1];
  assign blur_we     = vld_relay[READ_TO_WRITE-1];

  // Earlier strips kept, current strip replaced, later strips still empty
  always_comb begin
    for (int s = 0; s < STRIPS; s++) begin
      if (COL_W'(s) < rp.current_col)
        merged.strips[s] = blur_dout.strips[s];
      else if (COL_W'(s) == rp.current_col)
        merged.strips[s] = blur_strip;
      else
        merged.strips[s] = '0;
    end
  end

  always_ff @(posedge clk) begin
    blur_din <= merged;
  end

  // Seen by the sequencer one cycle after the last row lands
  always_ff @(posedge clk) begin
    if (!rst_n)
      rp.row_done <= 1'b0;
    else
      rp.row_done <= blur_we && (blur_addr_w == ROW_ADDR_W'(ROWS - 1));
  end

endmodule

/* hdl/strip_sequencer.sv */
`timescale 1ns/1ps

module strip_sequencer import blur_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  row_pass_if.sequencer         rp,
  output logic                  done,
  output logic                  buffer_we,
  output logic                  fill_zero,
  output logic [ROW_ADDR_W-1:0] img_addr
);

  seq_state_e state, state_nxt;
  logic [$clog2(PRELOAD_CYCLES)-1:0] pre_cnt;
  logic last_strip;
  logic strip_end;

  assign last_strip = (rp.current_col == COL_W'(STRIPS - 1));
  assign strip_end  = (state == ROW_PASS) && rp.row_done;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:
        if (start)
          state_nxt = PRELOAD;
      PRELOAD:
        if (pre_cnt == $bits(pre_cnt)'(PRELOAD_CYCLES - 1))
          state_nxt = ROW_PASS;
      ROW_PASS:
        if (rp.row_done)
          state_nxt = last_strip ? IDLE : PRELOAD;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      pre_cnt <= '0;
    else if (state == PRELOAD && state_nxt == PRELOAD)
      pre_cnt <= pre_cnt + 1'b1;
    else
      pre_cnt <= '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || state == IDLE)
      rp.current_col <= '0;
    else if (strip_end && !last_strip)
      rp.current_col <= rp.current_col + 1'b1;
  end

  // Image rows 0..2 during preload and then on up to ROWS
  always_ff @(posedge clk) begin
    if (!rst_n || state == IDLE || strip_end)
      img_addr <= '0;
    else if (state == PRELOAD || img_addr < ROW_ADDR_W'(ROWS))
      img_addr <= img_addr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      fill_zero <= 1'b0;
    else
      fill_zero <= (img_addr == ROW_ADDR_W'(ROWS));
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      done <= 1'b0;
    else if (state == IDLE && start)
      done <= 1'b0;
    else if (strip_end && last_strip)
      done <= 1'b1;
  end

  // First preload read only addresses the SRAM
  assign buffer_we = (state == PRELOAD && pre_cnt != '0) ||
                     (state == ROW_PASS && img_addr < ROW_ADDR_W'(ROWS));

  assign rp.row_phase   = (state == ROW_PASS);
  assign rp.strip_clear = (state == IDLE) || (state == PRELOAD && pre_cnt == '0);

endmodule

/* tb/gaussian_blur_assert.sv */
`timescale 1ns/1ps

module gaussian_blur_assert import blur_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  start,
  input logic                  done,
  input logic [ROW_ADDR_W-1:0] img_addr,
  input logic                  buffer_we,
  input logic                  fill_zero,
  input logic [COL_W-1:0]      current_col,
  input logic [ROW_ADDR_W-1:0] blur_addr_r,
  input logic [ROW_ADDR_W-1:0] blur_addr_w,
  input logic [ROW_W-1:0]      blur_din,
  input logic                  blur_we
);

  int unsigned           fail_count = 0;
  row_word_u             din_view;
  row_word_u             mem_view;
  logic                  img_end_q;
  logic [ROW_ADDR_W-1:0] rd_hist [READ_TO_WRITE];
  logic [ROW_ADDR_W-1:0] next_w;
  logic [COL_W:0]        strips_written;
  logic [PIX_W-1:0]      blur_pix;
  logic [STRIP_W-1:0]    merge_exp;
  logic [STRIP_W-1:0]    merge_act;
  int                    bad_strip;

  assign din_view.flat = blur_din;
  assign mem_view.flat = (blur_addr_w < ROW_ADDR_W'(ROWS)) ?
                         tb_gaussian_blur.blur_mem[blur_addr_w] : '0;

  // Uniform rows reduce the 3x3 kernel to (a + 2b + c) / 4
  always_comb begin
    int sum;
    sum = int'(tb_gaussian_blur.pix_a) + 2 * int'(tb_gaussian_blur.pix_b) +
          int'(tb_gaussian_blur.pix_c);
    blur_pix = PIX_W'(sum / 4);
  end

  // Lowest strip outside current_col that differs from the expected word
  always_comb begin
    logic [STRIP_W-1:0] want;
    bad_strip = -1;
    merge_exp = '0;
    merge_act = '0;
    for (int s = STRIPS - 1; s >= 0; s--) begin
      want = (s < int'(current_col)) ? mem_view.strips[s] : '0;
      if (s != int'(current_col) && din_view.strips[s] != want) begin
        bad_strip = s;
        merge_exp = want;
        merge_act = din_view.strips[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    img_end_q <= (img_addr == ROW_ADDR_W'(ROWS));
    rd_hist[0] <= blur_addr_r;
    for (int i = 1; i < READ_TO_WRITE; i++)
      rd_hist[i] <= rd_hist[i-1];
    if (!rst_n)
      next_w <= '0;
    else if (blur_we)
      next_w <= (blur_addr_w == ROW_ADDR_W'(ROWS - 1)) ? '0 : blur_addr_w + 1'b1;
    if (!rst_n || (done && start))
      strips_written <= '0;
    else if (blur_we && blur_addr_w == ROW_ADDR_W'(ROWS - 1))
      strips_written <= strips_written + 1'b1;
  end

  a_reset_ctrl: assert property (@(posedge clk)
    $rose(rst_n) |-> !(done || buffer_we || blur_we || fill_zero))
    else begin
      fail_count++;
      $error("FAIL t=%0t done,buffer_we,blur_we,fill_zero expected 0000 actual %b%b%b%b",
             $time, $sampled(done), $sampled(buffer_we), $sampled(blur_we),
             $sampled(fill_zero));
    end

  a_reset_col: assert property (@(posedge clk) $rose(rst_n) |-> current_col == '0)
    else begin
      fail_count++;
      $error("FAIL t=%0t current_col expected 0 actual %0d", $time, $sampled(current_col));
    end

  a_fill_zero: assert property (@(posedge clk) disable iff (!rst_n) fill_zero == img_end_q)
    else begin
      fail_count++;
      $error("FAIL t=%0t fill_zero expected %b actual %b", $time,
             $sampled(img_end_q), $sampled(fill_zero));
    end

  a_buffer_we: assert property (@(posedge clk) disable iff (!rst_n)
    buffer_we |-> img_addr < ROW_ADDR_W'(ROWS))
    else begin
      fail_count++;
      $error("FAIL t=%0t img_addr expected below %0d actual %0d", $time, ROWS,
             $sampled(img_addr));
    end

  a_write_range: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> blur_addr_w < ROW_ADDR_W'(ROWS))
    else begin
      fail_count++;
      $error("FAIL t=%0t blur_addr_w expected below %0d actual %0d", $time, ROWS,
             $sampled(blur_addr_w));
    end

  a_write_order: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> blur_addr_w == next_w)
    else begin
      fail_count++;
      $error("FAIL t=%0t blur_addr_w expected %0d actual %0d", $time,
             $sampled(next_w), $sampled(blur_addr_w));
    end

  // Write address trails the read address by the fixed latency
  a_read_to_write: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> blur_addr_w == rd_hist[READ_TO_WRITE-1])
    else begin
      fail_count++;
      $error("FAIL t=%0t blur_addr_w expected blur_addr_r %0d actual %0d", $time,
             $sampled(rd_hist[READ_TO_WRITE-1]), $sampled(blur_addr_w));
    end

  a_kernel: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> din_view.strips[current_col] == {STRIP_PIX{blur_pix}})
    else begin
      fail_count++;
      $error("FAIL t=%0t blur_din strip %0d expected %h actual %h", $time,
             $sampled(current_col), {STRIP_PIX{$sampled(blur_pix)}},
             $sampled(din_view.strips[current_col]));
    end

  a_merge: assert property (@(posedge clk) disable iff (!rst_n) blur_we |-> bad_strip < 0)
    else begin
      fail_count++;
      $error("FAIL t=%0t blur_din strip %0d expected %h actual %h", $time,
             $sampled(bad_strip), $sampled(merge_exp), $sampled(merge_act));
    end

  a_col_max: assert property (@(posedge clk) disable iff (!rst_n)
    current_col <= COL_W'(STRIPS - 1))
    else begin
      fail_count++;
      $error("FAIL t=%0t current_col expected at most %0d actual %0d", $time,
             STRIPS - 1, $sampled(current_col));
    end

  a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> strips_written == (COL_W + 1)'(STRIPS))
    else begin
      fail_count++;
      $error("FAIL t=%0t strips written at done expected %0d actual %0d", $time,
             STRIPS, $sampled(strips_written));
    end

  a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
    done && !start |=> done)
    else begin
      fail_count++;
      $error("FAIL t=%0t done expected 1 actual %b", $time, $sampled(done));
    end

endmodule

/* tb/tb_gaussian_blur.sv */
`timescale 1ns/1ps

module tb_gaussian_blur import blur_pkg::*; ();

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  logic                     done;
  logic [ROW_ADDR_W-1:0]    img_addr;
  logic                     buffer_we;
  logic                     fill_zero;
  logic [COL_W-1:0]         current_col;
  logic [BUF_PIX*PIX_W-1:0] buf_row_0;
  logic [BUF_PIX*PIX_W-1:0] buf_row_1;
  logic [BUF_PIX*PIX_W-1:0] buf_row_2;
  logic [ROW_ADDR_W-1:0]    blur_addr_r;
  logic [ROW_W-1:0]         blur_dout = '0;
  logic [ROW_ADDR_W-1:0]    blur_addr_w;
  logic [ROW_W-1:0]         blur_din;
  logic                     blur_we;

  // Blur SRAM model
  logic [ROW_W-1:0]         blur_mem [ROWS];
  logic [ROW_ADDR_W-1:0]    rd_addr_q = '0;

  // Values of the three uniform buffer rows for the current strip
  logic [PIX_W-1:0]         pix_a;
  logic [PIX_W-1:0]         pix_b;
  logic [PIX_W-1:0]         pix_c;
  integer                   seed = 39804;

  gaussian_blur dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .buffer_we   (buffer_we),
    .fill_zero   (fill_zero),
    .current_col (current_col),
    .buf_row_0   (buf_row_0),
    .buf_row_1   (buf_row_1),
    .buf_row_2   (buf_row_2),
    .blur_addr_r (blur_addr_r),
    .blur_dout   (blur_dout),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din),
    .blur_we     (blur_we)
  );

  bind gaussian_blur gaussian_blur_assert u_chk (
    .clk(clk), .rst_n(rst_n), .start(start), .done(done), .img_addr(img_addr),
    .buffer_we(buffer_we), .fill_zero(fill_zero), .current_col(current_col),
    .blur_addr_r(blur_addr_r), .blur_addr_w(blur_addr_w), .blur_din(blur_din),
    .blur_we(blur_we)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Read data appears two edges after the address
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < ROWS; r++)
        blur_mem[r] <= {(ROW_W / 32){32'(r) * 32'h9e37_79b1}};
    end else if (blur_we && blur_addr_w < ROW_ADDR_W'(ROWS)) begin
      blur_mem[blur_addr_w] <= blur_din;
    end
    rd_addr_q <= blur_addr_r;
    blur_dout <= (rd_addr_q < ROW_ADDR_W'(ROWS)) ? blur_mem[rd_addr_q] : '0;
  end

  always @(negedge clk) begin
    if (dut.u_chk.fail_count != 0) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Checker assertion failed");
    end
  end

  task automatic stop_on_timeout(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic draw_pixels();
    logic [PIX_W-1:0] a;
    logic [PIX_W-1:0] b;
    logic [PIX_W-1:0] c;
    a = PIX_W'($random(seed));
    b = PIX_W'($random(seed));
    c = PIX_W'($random(seed));
    pix_a     <= a;
    pix_b     <= b;
    pix_c     <= c;
    buf_row_0 <= {BUF_PIX{a}};
    buf_row_1 <= {BUF_PIX{b}};
    buf_row_2 <= {BUF_PIX{c}};
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_for_col(input logic [COL_W-1:0] target, input int limit);
    int n;
    n = 0;
    while (current_col != target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (current_col != target)
      stop_on_timeout($sformatf("Timed out waiting for strip %0d to begin", target));
  endtask

  task automatic wait_for_done(input logic level, input int limit);
    int n;
    n = 0;
    while (done != level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (done != level)
      stop_on_timeout($sformatf("Timed out waiting for done to become %b", level));
  endtask

  initial begin
    rst_n <= 1'b0;
    start <= 1'b0;
    draw_pixels();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    pulse_start();
    for (int s = 1; s < STRIPS; s++) begin
      wait_for_col(COL_W'(s), 1000);
      draw_pixels();
    end
    wait_for_done(1'b1, 1000);
    // Idle with done high until a second start clears it
    repeat (8) @(posedge clk);
    pulse_start();
    wait_for_done(1'b0, 20);
    repeat (4) @(posedge clk);
    if (dut.u_chk.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Checker assertion failed");
    end
  end

endmodule

/* verilog.f */
hdl/blur_pkg.sv
hdl/row_pass_if.sv
hdl/strip_sequencer.sv
hdl/gauss3_kernel.sv
hdl/row_writeback.sv
hdl/gaussian_blur.sv
tb/gaussian_blur_assert.sv
tb/tb_gaussian_blur.sv
